// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_backend
FILELIST  := project.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) backend_config.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN) backend_vectors.txt
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== backend_config.svh ====
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// Integer datapath width
`define XLEN 64

// Architectural register addressing
`define REG_ADDR_W 5
`define NUM_REGS 32

// Busy cycles per multiply request before the result shows up
`define MUL_LATENCY 4

`endif

// ==== backend_exec_pipe.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module backend_exec_pipe (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       issue_valid_i,
  input  backend_pipe_pkg::decoded_t issue_i,
  input  logic [`XLEN-1:0]           alu_result_i,
  input  logic                       mul_valid_i,
  input  logic [`XLEN-1:0]           mul_data_i,
  output backend_pipe_pkg::stage_t   ex1_o,
  output backend_pipe_pkg::stage_t   ex2_o,
  output logic                       ex1_data_valid_o,
  output logic [`XLEN-1:0]           ex1_data_o,
  output logic                       ex2_data_valid_o,
  output logic [`XLEN-1:0]           ex2_data_o,
  output logic                       ex1_ready_o,
  output backend_pipe_pkg::commit_t  commit_o
);

  backend_pipe_pkg::stage_t ex1_q, ex1_d;
  backend_pipe_pkg::stage_t ex2_q, ex2_d;
  logic ex2_ready;

  ////////////////////////////////////////////////////////////
  // Result selection

  // While EX2 waits on the multiplier, its valid belongs to EX2
  assign ex1_data_valid_o = ex1_q.select == backend_pipe_pkg::FU_ALU ||
                            (mul_valid_i && ex2_q.select != backend_pipe_pkg::FU_MUL);
  assign ex1_data_o = ex1_q.select == backend_pipe_pkg::FU_ALU ? ex1_q.alu_data : mul_data_i;

  assign ex2_data_valid_o = ex2_q.select == backend_pipe_pkg::FU_ALU || mul_valid_i;
  assign ex2_data_o = ex2_q.select == backend_pipe_pkg::FU_ALU ? ex2_q.alu_data : mul_data_i;

  assign ex2_ready = !ex2_q.pending || ex2_data_valid_o;
  assign ex1_ready_o = ex2_ready || !ex1_q.pending;

  ////////////////////////////////////////////////////////////
  // EX1 stage

  always_comb begin
    ex1_d = ex1_q;
    // Park a finished result so it is not lost while EX1 waits
    if (ex1_data_valid_o) begin
      ex1_d.select = backend_pipe_pkg::FU_ALU;
      ex1_d.alu_data = ex1_data_o;
    end
    if (ex2_ready) begin
      ex1_d.pending = 1'b0;
      ex1_d.select = backend_pipe_pkg::FU_ALU;
      ex1_d.rd = '0;
    end
    if (issue_valid_i) begin
      ex1_d.pending = 1'b1;
      ex1_d.select = issue_i.func_unit;
      ex1_d.rd = issue_i.rd;
      ex1_d.alu_data = alu_result_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX2 stage

  always_comb begin
    ex2_d = ex2_q;
    if (ex2_data_valid_o) begin
      ex2_d.pending = 1'b0;
      ex2_d.select = backend_pipe_pkg::FU_ALU;
      ex2_d.rd = '0;
    end
    if (ex1_q.pending && ex2_ready) begin
      ex2_d.pending = 1'b1;
      ex2_d.select = ex1_q.select;
      ex2_d.rd = ex1_q.rd;
      if (ex1_data_valid_o) begin
        ex2_d.select = backend_pipe_pkg::FU_ALU;
        ex2_d.alu_data = ex1_data_o;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex1_q.pending <= 1'b0;
      ex1_q.select <= backend_pipe_pkg::FU_ALU;
      ex1_q.rd <= '0;
      ex2_q.pending <= 1'b0;
      ex2_q.select <= backend_pipe_pkg::FU_ALU;
      ex2_q.rd <= '0;
    end else begin
      ex1_q <= ex1_d;
      ex2_q <= ex2_d;
    end
  end

  assign ex1_o = ex1_q;
  assign ex2_o = ex2_q;

  assign commit_o.valid = ex2_q.pending && ex2_data_valid_o;
  assign commit_o.rd = ex2_q.rd;
  assign commit_o.data = ex2_data_o;

  // Only one stage at a time can wait on the multiplier
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex2_q.pending && ex2_q.select == backend_pipe_pkg::FU_MUL |->
      !(ex1_q.pending && ex1_q.select == backend_pipe_pkg::FU_MUL));

endmodule

// ==== backend_isa_pkg.sv ====
package backend_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction formats

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // One fetched word read through the view its opcode calls for
  typedef union packed {
    r_fmt_t r_view;
    i_fmt_t i_view;
  } instr_u;

  ////////////////////////////////////////////////////////////
  // Encodings

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL     = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

endpackage

// ==== backend_issue.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module backend_issue (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fetch_valid_i,
  output logic                       fetch_ready_o,
  input  backend_isa_pkg::instr_u    fetch_instr_i,
  output logic [`REG_ADDR_W-1:0]     rs1_addr_o,
  output logic [`REG_ADDR_W-1:0]     rs2_addr_o,
  input  logic [`XLEN-1:0]           rs1_data_i,
  input  logic [`XLEN-1:0]           rs2_data_i,
  input  backend_pipe_pkg::stage_t   ex1_i,
  input  backend_pipe_pkg::stage_t   ex2_i,
  input  logic                       ex1_data_valid_i,
  input  logic [`XLEN-1:0]           ex1_data_i,
  input  logic                       ex2_data_valid_i,
  input  logic [`XLEN-1:0]           ex2_data_i,
  input  logic                       ex1_ready_i,
  input  logic                       mul_ready_i,
  output logic                       issue_valid_o,
  output backend_pipe_pkg::decoded_t issue_o,
  output logic [`XLEN-1:0]           alu_result_o,
  output logic                       mul_req_o,
  output logic [`XLEN-1:0]           mul_a_o,
  output logic [`XLEN-1:0]           mul_b_o
);

  localparam int ShamtW = $clog2(`XLEN);

  ////////////////////////////////////////////////////////////
  // Decode

  backend_pipe_pkg::decoded_t dec;
  backend_pipe_pkg::decoded_t de_q;
  logic de_valid_q;

  always_comb begin
    dec = '0;
    dec.alu_op = backend_isa_pkg::ALU_ADD;
    dec.func_unit = backend_pipe_pkg::FU_ALU;
    if (fetch_instr_i.i_view.opcode == backend_isa_pkg::OPC_OP_IMM) begin
      dec.rs1 = fetch_instr_i.i_view.rs1;
      dec.rd = fetch_instr_i.i_view.rd;
      dec.use_imm = 1'b1;
      dec.imm = {{(`XLEN-12){fetch_instr_i.i_view.imm12[11]}}, fetch_instr_i.i_view.imm12};
      case (fetch_instr_i.i_view.funct3)
        backend_isa_pkg::FUNCT3_XOR: dec.alu_op = backend_isa_pkg::ALU_XOR;
        backend_isa_pkg::FUNCT3_OR:  dec.alu_op = backend_isa_pkg::ALU_OR;
        backend_isa_pkg::FUNCT3_AND: dec.alu_op = backend_isa_pkg::ALU_AND;
        default: ;
      endcase
    end else begin
      dec.rs1 = fetch_instr_i.r_view.rs1;
      dec.rs2 = fetch_instr_i.r_view.rs2;
      dec.rd = fetch_instr_i.r_view.rd;
      if (fetch_instr_i.r_view.opcode == backend_isa_pkg::OPC_OP) begin
        unique case (fetch_instr_i.r_view.funct7)
          backend_isa_pkg::FUNCT7_MULDIV: begin
            if (fetch_instr_i.r_view.funct3 == backend_isa_pkg::FUNCT3_ADD_SUB) begin
              dec.func_unit = backend_pipe_pkg::FU_MUL;
            end
          end
          backend_isa_pkg::FUNCT7_SUB: begin
            if (fetch_instr_i.r_view.funct3 == backend_isa_pkg::FUNCT3_ADD_SUB) begin
              dec.alu_op = backend_isa_pkg::ALU_SUB;
            end
          end
          backend_isa_pkg::FUNCT7_BASE: begin
            case (fetch_instr_i.r_view.funct3)
              backend_isa_pkg::FUNCT3_SLL: dec.alu_op = backend_isa_pkg::ALU_SLL;
              backend_isa_pkg::FUNCT3_XOR: dec.alu_op = backend_isa_pkg::ALU_XOR;
              backend_isa_pkg::FUNCT3_SRL: dec.alu_op = backend_isa_pkg::ALU_SRL;
              backend_isa_pkg::FUNCT3_OR:  dec.alu_op = backend_isa_pkg::ALU_OR;
              backend_isa_pkg::FUNCT3_AND: dec.alu_op = backend_isa_pkg::ALU_AND;
              default: ;
            endcase
          end
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Bypass and hazards

  logic data_hazard;
  logic struct_hazard;
  logic issue;
  logic [`XLEN-1:0] ex_rs1;
  logic [`XLEN-1:0] ex_rs2;

  function automatic logic fwd_hit(backend_pipe_pkg::stage_t st,
                                   logic [`REG_ADDR_W-1:0] addr);
    return st.pending && st.rd == addr && addr != '0;
  endfunction

  // EX2 first so that the younger EX1 result wins
  always_comb begin
    data_hazard = 1'b0;
    ex_rs1 = rs1_data_i;
    ex_rs2 = rs2_data_i;
    if (fwd_hit(ex2_i, de_q.rs1)) begin
      if (ex2_data_valid_i) ex_rs1 = ex2_data_i;
      else data_hazard = 1'b1;
    end
    if (fwd_hit(ex1_i, de_q.rs1)) begin
      if (ex1_data_valid_i) ex_rs1 = ex1_data_i;
      else data_hazard = 1'b1;
    end
    if (fwd_hit(ex2_i, de_q.rs2)) begin
      if (ex2_data_valid_i) ex_rs2 = ex2_data_i;
      else data_hazard = 1'b1;
    end
    if (fwd_hit(ex1_i, de_q.rs2)) begin
      if (ex1_data_valid_i) ex_rs2 = ex1_data_i;
      else data_hazard = 1'b1;
    end
  end

  assign struct_hazard = !ex1_ready_i ||
                         (de_q.func_unit == backend_pipe_pkg::FU_MUL && !mul_ready_i);
  assign issue = de_valid_q && !data_hazard && !struct_hazard;
  assign fetch_ready_o = !de_valid_q || (!data_hazard && !struct_hazard);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      de_valid_q <= 1'b0;
    end else if (fetch_valid_i && fetch_ready_o) begin
      de_valid_q <= 1'b1;
    end else if (issue) begin
      de_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid_i && fetch_ready_o) begin
      de_q <= dec;
    end
  end

  // Register file reads follow the decode register
  assign rs1_addr_o = de_q.rs1;
  assign rs2_addr_o = de_q.rs2;

  ////////////////////////////////////////////////////////////
  // ALU

  logic [`XLEN-1:0] op_b;
  logic [ShamtW-1:0] shamt;

  assign op_b = de_q.use_imm ? de_q.imm : ex_rs2;
  assign shamt = op_b[ShamtW-1:0];

  always_comb begin
    case (de_q.alu_op)
      backend_isa_pkg::ALU_SUB: alu_result_o = ex_rs1 - op_b;
      backend_isa_pkg::ALU_AND: alu_result_o = ex_rs1 & op_b;
      backend_isa_pkg::ALU_OR:  alu_result_o = ex_rs1 | op_b;
      backend_isa_pkg::ALU_XOR: alu_result_o = ex_rs1 ^ op_b;
      backend_isa_pkg::ALU_SLL: alu_result_o = ex_rs1 << shamt;
      backend_isa_pkg::ALU_SRL: alu_result_o = ex_rs1 >> shamt;
      default:                  alu_result_o = ex_rs1 + op_b;
    endcase
  end

  assign issue_valid_o = issue;
  assign issue_o = de_q;
  assign mul_req_o = issue && de_q.func_unit == backend_pipe_pkg::FU_MUL;
  assign mul_a_o = ex_rs1;
  assign mul_b_o = ex_rs2;

  // Only a multiplier result can still be outstanding when issue sees a data hazard
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_hazard |->
      (ex1_i.pending && ex1_i.select == backend_pipe_pkg::FU_MUL) ||
      (ex2_i.pending && ex2_i.select == backend_pipe_pkg::FU_MUL));

endmodule

// ==== backend_mul.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module backend_mul (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  logic [`XLEN-1:0] operand_a_i,
  input  logic [`XLEN-1:0] operand_b_i,
  output logic             resp_valid_o,
  output logic [`XLEN-1:0] resp_value_o
);

  localparam int CntW = $clog2(`MUL_LATENCY + 1);

  logic [CntW-1:0] count_q;
  logic [`XLEN-1:0] a_q;
  logic [`XLEN-1:0] b_q;

  assign req_ready_o = count_q == '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      resp_valid_o <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      count_q <= CntW'(`MUL_LATENCY);
      resp_valid_o <= 1'b0;
    end else if (count_q != '0) begin
      count_q <= count_q - CntW'(1);
      // The product becomes visible after the last busy cycle
      resp_valid_o <= count_q == CntW'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      a_q <= operand_a_i;
      b_q <= operand_b_i;
    end
    if (count_q == CntW'(1)) begin
      // Low half of the product only
      resp_value_o <= a_q * b_q;
    end
  end

  // Issue must hold back a MUL until the unit is free
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q != '0 |-> !req_valid_i);

endmodule

// ==== backend_pipe_pkg.sv ====
`include "backend_config.svh"

package backend_pipe_pkg;

  typedef enum logic {
    FU_ALU,
    FU_MUL
  } func_unit_e;

  // Content of the decode register
  typedef struct packed {
    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic [`REG_ADDR_W-1:0]  rd;
    logic                    use_imm;
    logic [`XLEN-1:0]        imm;
    backend_isa_pkg::alu_op_e alu_op;
    func_unit_e              func_unit;
  } decoded_t;

  // State of one execute stage that the bypass network also reads
  typedef struct packed {
    logic                   pending;
    func_unit_e             select;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       alu_data;
  } stage_t;

  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } commit_t;

endpackage

// ==== backend_top.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module backend_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_valid_i,
  output logic                      fetch_ready_o,
  input  backend_isa_pkg::instr_u   fetch_instr_i,
  output backend_pipe_pkg::commit_t commit_o
);

  logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [`XLEN-1:0] rs1_data, rs2_data;
  backend_pipe_pkg::stage_t ex1, ex2;
  logic ex1_data_valid, ex2_data_valid, ex1_ready;
  logic [`XLEN-1:0] ex1_data, ex2_data;
  logic issue_valid;
  backend_pipe_pkg::decoded_t issue;
  logic [`XLEN-1:0] alu_result;
  logic mul_req, mul_ready, mul_valid;
  logic [`XLEN-1:0] mul_a, mul_b, mul_data;
  backend_pipe_pkg::commit_t commit;

  backend_issue u_issue (
    .clk_i, .rst_ni, .fetch_valid_i, .fetch_ready_o, .fetch_instr_i,
    .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
    .ex1_i (ex1), .ex2_i (ex2),
    .ex1_data_valid_i (ex1_data_valid), .ex1_data_i (ex1_data),
    .ex2_data_valid_i (ex2_data_valid), .ex2_data_i (ex2_data),
    .ex1_ready_i (ex1_ready), .mul_ready_i (mul_ready),
    .issue_valid_o (issue_valid), .issue_o (issue), .alu_result_o (alu_result),
    .mul_req_o (mul_req), .mul_a_o (mul_a), .mul_b_o (mul_b)
  );

  backend_mul u_mul (
    .clk_i, .rst_ni,
    .req_valid_i (mul_req), .req_ready_o (mul_ready),
    .operand_a_i (mul_a), .operand_b_i (mul_b),
    .resp_valid_o (mul_valid), .resp_value_o (mul_data)
  );

  backend_exec_pipe u_exec (
    .clk_i, .rst_ni,
    .issue_valid_i (issue_valid), .issue_i (issue), .alu_result_i (alu_result),
    .mul_valid_i (mul_valid), .mul_data_i (mul_data),
    .ex1_o (ex1), .ex2_o (ex2),
    .ex1_data_valid_o (ex1_data_valid), .ex1_data_o (ex1_data),
    .ex2_data_valid_o (ex2_data_valid), .ex2_data_o (ex2_data),
    .ex1_ready_o (ex1_ready), .commit_o (commit)
  );

  backend_writeback u_wb (
    .clk_i, .rst_ni,
    .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data), .rs2_data_o (rs2_data),
    .commit_i (commit), .commit_o
  );

endmodule

// ==== backend_vectors.txt ====
// Columns: instruction word, expected commit rd, expected commit data (all hex)
// One instruction per line, commits are expected in this order
00500093 01 0000000000000005
ffd00113 02 fffffffffffffffd
002081b3 03 0000000000000002
40118233 04 fffffffffffffffd
0f024293 05 ffffffffffffff0d
7ff2f313 06 000000000000070d
0a036393 07 00000000000007ad
00139433 08 000000000000f5a0
001154b3 09 07ffffffffffffff
00346533 0a 000000000000f5a2
005545b3 0b ffffffffffff0aaf
0095f633 0c 07ffffffffff0aaf
// MUL followed by a dependent ADDI
02a086b3 0d 000000000004cc2a
00168713 0e 000000000004cc2b
022107b3 0f 0000000000000009
00308833 10 0000000000000007
02c788b3 11 47fffffffff76027
41088933 12 47fffffffff76020
// Writes to x0 commit, later reads of x0 still see zero
00708013 00 000000000000000c
001009b3 13 0000000000000005
02108033 00 0000000000000019
55506a13 14 0000000000000555
41400ab3 15 fffffffffffffaab
00dacb33 16 fffffffffffb3681
00eb0bb3 17 00000000000002ac

// ==== backend_writeback.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module backend_writeback (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`REG_ADDR_W-1:0]    rs1_addr_i,
  input  logic [`REG_ADDR_W-1:0]    rs2_addr_i,
  output logic [`XLEN-1:0]          rs1_data_o,
  output logic [`XLEN-1:0]          rs2_data_o,
  input  backend_pipe_pkg::commit_t commit_i,
  output backend_pipe_pkg::commit_t commit_o
);

  logic [`XLEN-1:0] regs_q [`NUM_REGS];

  ////////////////////////////////////////////////////////////
  // Integer register file

  // x0 is cleared at reset and never written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (commit_i.valid && commit_i.rd != '0) begin
      regs_q[commit_i.rd] <= commit_i.data;
    end
  end

  // Asynchronous read ports
  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];

  // Trace of retired instructions in the same cycle as the write enable
  assign commit_o = commit_i;

endmodule

// ==== project.f ====
+incdir+.
backend_isa_pkg.sv
backend_pipe_pkg.sv
backend_issue.sv
backend_mul.sv
backend_exec_pipe.sv
backend_writeback.sv
backend_top.sv
tb_clock_gen.sv
tb_backend.sv

// ==== tb_backend.sv ====
`timescale 1ns/1ps
`include "backend_config.svh"

module tb_backend;

  localparam int MaxVectors = 64;

  logic clk;
  logic rst_n;
  logic fetch_valid;
  logic fetch_ready;
  backend_isa_pkg::instr_u fetch_instr;
  backend_pipe_pkg::commit_t commit;

  // Three words per vector hold the instruction, destination register and result
  logic [63:0] vec_mem [3*MaxVectors];
  int num_vectors;
  int commit_count;
  int error_count;
  int cycle_count;
  int cycle_limit;
  logic fetch_started;
  integer seed;

  tb_clock_gen u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  backend_top uut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .fetch_instr_i (fetch_instr),
    .commit_o      (commit)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus

  task automatic load_vectors();
    // Unused entries get a nonzero upper half, which marks the end of the list
    for (int i = 0; i < 3*MaxVectors; i++) begin
      vec_mem[i] = {~32'(i), 32'(i)};
    end
    $readmemh("backend_vectors.txt", vec_mem);
    num_vectors = 0;
    while (num_vectors < MaxVectors && vec_mem[3*num_vectors][63:32] == '0) begin
      num_vectors++;
    end
  endtask

  // Mostly back to back with now and then one or two idle cycles
  function automatic int pick_gap();
    int r;
    r = $random(seed) & 7;
    return (r > 2) ? 0 : r;
  endfunction

  task automatic drive_stream();
    int gap;
    logic accepted;
    for (int idx = 0; idx < num_vectors; idx++) begin
      gap = pick_gap();
      if (gap > 0) begin
        fetch_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      fetch_valid <= 1'b1;
      fetch_instr <= vec_mem[3*idx][31:0];
      accepted = 1'b0;
      while (!accepted) begin
        // Ready is settled by the falling edge
        @(negedge clk);
        accepted = fetch_ready;
        @(posedge clk);
      end
      fetch_started = 1'b1;
    end
    fetch_valid <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Commit checking

  task automatic check_commit();
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic [`XLEN-1:0] exp_data;
    if (!fetch_started) begin
      $display("A commit appeared before any instruction was accepted");
      error_count++;
    end else if (commit_count >= num_vectors) begin
      $display("A commit appeared after the last expected instruction");
      error_count++;
    end else begin
      exp_rd = vec_mem[3*commit_count+1][`REG_ADDR_W-1:0];
      exp_data = vec_mem[3*commit_count+2];
      if (commit.rd != exp_rd) begin
        $display("Error: commit_o.rd = 0x%0h, expected 0x%0h (vector %0d)",
                 commit.rd, exp_rd, commit_count);
        error_count++;
      end
      if (commit.data != exp_data) begin
        $display("Error: commit_o.data = 0x%0h, expected 0x%0h (vector %0d)",
                 commit.data, exp_data, commit_count);
        error_count++;
      end
      commit_count++;
    end
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      if (commit.valid) begin
        $display("Commit valid was high during reset");
        error_count++;
      end
    end else if (commit.valid) begin
      check_commit();
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the commit stream did not complete", cycle_count);
      $display("Vectors: %0d, commits: %0d, errors: %0d",
               num_vectors, commit_count, error_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed = 32'he38f61f9;
    error_count = 0;
    commit_count = 0;
    cycle_count = 0;
    fetch_started = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    load_vectors();
    cycle_limit = num_vectors * (`MUL_LATENCY + 8) + 50;
    if (num_vectors == 0) begin
      $display("No vectors were loaded from backend_vectors.txt");
      error_count++;
    end

    @(posedge rst_n);
    @(negedge clk);
    if (!fetch_ready) begin
      $display("Fetch ready was low right after reset");
      error_count++;
    end
    @(posedge clk);

    drive_stream();
    while (commit_count < num_vectors) begin
      @(posedge clk);
    end
    // Idle tail so that a stray extra commit is still caught
    repeat (8) @(posedge clk);

    $display("Vectors: %0d, commits: %0d, errors: %0d",
             num_vectors, commit_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HalfPeriodNs = 20,
  parameter int ResetCycles  = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // Reset is released on a rising edge so the first active cycle is a full one
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule
